// ==== rtl/core_consts.svh ====
// routing core constants
// register addresses, readback selectors, widths and engine count
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// engine slots behind the router
`define CORE_NUM_CE          2

// stream and counter widths
`define CORE_DATA_W          64
`define CORE_DROP_W          16

// settings bus word addresses
`define CORE_SR_READBACK     11'd0
`define CORE_SR_MISC         11'd4
`define CORE_SR_TEST         11'd28
`define CORE_SR_XB_LOCAL     11'd32

// readback selectors
`define CORE_RB_MISC         5'd1
`define CORE_RB_COMPAT       5'd2
`define CORE_RB_PLL          5'd4
`define CORE_RB_DROPS        5'd5
`define CORE_RB_TEST         5'd24

// fixed values
`define CORE_COMPAT_WORD     32'hAC000B00
`define CORE_RB_DEFAULT      32'hDEADBEEF
`define CORE_XB_LOCAL_RESET  8'd40
`define CORE_MISC_RESET      32'd2

`endif

// ==== rtl/core_pkg.sv ====
// routing core types
// stream beat, misc control word and state/selector enums
`default_nettype none
`include "core_consts.svh"

package core_pkg;

  // one beat of the 64-bit packet stream
  typedef struct packed {
    logic                    last;
    logic [`CORE_DATA_W-1:0] data;
  } stream_beat_t;

  // misc register layout, lsb first at the bottom
  typedef struct packed {
    logic [10:0] reserved;
    logic [3:0]  rx_bandsel_c;
    logic [3:0]  rx_bandsel_b;
    logic [5:0]  rx_bandsel_a;
    logic [2:0]  tx_bandsel;
    logic        codec_arst;
    logic        mimo;
    logic [1:0]  pps_select;
  } misc_ctrl_t;

  // packet position for router and merge
  typedef enum logic {
    ST_HEADER,
    ST_BODY
  } route_state_e;

  // readback selector codes
  typedef enum logic [4:0] {
    RB_MISC   = `CORE_RB_MISC,
    RB_COMPAT = `CORE_RB_COMPAT,
    RB_PLL    = `CORE_RB_PLL,
    RB_DROPS  = `CORE_RB_DROPS,
    RB_TEST   = `CORE_RB_TEST
  } rb_sel_e;

endpackage

`default_nettype wire

// ==== rtl/core_settings.sv ====
// global settings registers
// readback selector, test, misc and local address, plus the readback mux
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_settings
  import core_pkg::*;
(
  input  wire logic                    i_bus_clk,
  input  wire logic                    i_bus_rst,
  input  wire logic                    i_set_stb,
  input  wire logic [31:0]             i_set_addr,
  input  wire logic [31:0]             i_set_data,
  input  wire logic [1:0]              i_lock_signals,
  input  wire logic [3:0]              i_tcxo_status,
  input  wire logic [`CORE_DROP_W-1:0] i_drop_count,
  output logic      [31:0]             o_rb_data,
  output misc_ctrl_t                   o_misc,
  output logic      [7:0]              o_xb_local_addr
);

  rb_sel_e     rb_sel;
  logic [31:0] test_reg;
  misc_ctrl_t  misc_reg;
  logic [7:0]  xb_local;
  logic [1:0]  lock_meta;
  logic [1:0]  lock_sync;

  //////////////////////////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////////////////////////

  // only the low 11 address bits decode
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      rb_sel   <= rb_sel_e'(5'd0);
      test_reg <= '0;
      misc_reg <= misc_ctrl_t'(`CORE_MISC_RESET);
      xb_local <= `CORE_XB_LOCAL_RESET;
    end else if (i_set_stb) begin
      case (i_set_addr[10:0])
        `CORE_SR_READBACK: rb_sel   <= rb_sel_e'(i_set_data[4:0]);
        `CORE_SR_MISC:     misc_reg <= misc_ctrl_t'(i_set_data);
        `CORE_SR_TEST:     test_reg <= i_set_data;
        `CORE_SR_XB_LOCAL: xb_local <= i_set_data[7:0];
        default: ;
      endcase
    end
  end

  // pll lock bits come from another domain, two flops
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      lock_meta <= 2'b00;
      lock_sync <= 2'b00;
    end else begin
      lock_meta <= i_lock_signals;
      lock_sync <= lock_meta;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (rb_sel)
      RB_TEST:   o_rb_data = test_reg;
      RB_MISC:   o_rb_data = {26'd0, i_tcxo_status, misc_reg.pps_select};
      RB_COMPAT: o_rb_data = `CORE_COMPAT_WORD;
      RB_PLL:    o_rb_data = {30'd0, lock_sync};
      RB_DROPS:  o_rb_data = {{(32-`CORE_DROP_W){1'b0}}, i_drop_count};
      default:   o_rb_data = `CORE_RB_DEFAULT;
    endcase
  end

  assign o_misc          = misc_reg;
  assign o_xb_local_addr = xb_local;

endmodule

`default_nettype wire

// ==== rtl/pkt_router.sv ====
// packet demux by header destination
// foreign or out-of-range packets are swallowed and counted
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module pkt_router
  import core_pkg::*;
#(
  parameter int NUM_OUT = 2
) (
  input  wire logic                    i_bus_clk,
  input  wire logic                    i_bus_rst,
  input  wire logic [7:0]              i_local_addr,
  input  wire stream_beat_t            i_beat,
  input  wire logic                    i_valid,
  output logic                         o_ready,
  output stream_beat_t                 o_beat [NUM_OUT],
  output logic      [NUM_OUT-1:0]      o_valid,
  input  wire logic [NUM_OUT-1:0]      i_ready,
  output logic      [`CORE_DROP_W-1:0] o_drop_count
);

  localparam int SEL_W = (NUM_OUT > 1) ? $clog2(NUM_OUT) : 1;

  route_state_e            state;
  logic [SEL_W-1:0]        body_sel;
  logic                    body_drop;
  logic [SEL_W-1:0]        hdr_sel;
  logic                    hdr_drop;
  logic [SEL_W-1:0]        cur_sel;
  logic                    cur_drop;
  logic                    fire;
  logic [`CORE_DROP_W-1:0] drop_count;

  // header decode, device in 15:8 and engine in 7:0
  assign hdr_drop = (i_beat.data[15:8] != i_local_addr) ||
                    (i_beat.data[7:0] >= 8'(NUM_OUT));
  assign hdr_sel  = i_beat.data[SEL_W-1:0];

  // header beat routes itself, body follows the latch
  assign cur_sel  = (state == ST_HEADER) ? hdr_sel  : body_sel;
  assign cur_drop = (state == ST_HEADER) ? hdr_drop : body_drop;

  // dropped beats are always accepted
  assign o_ready = cur_drop ? 1'b1 : i_ready[cur_sel];
  assign fire    = i_valid && o_ready;

  for (genvar k = 0; k < NUM_OUT; k++) begin : g_out
    assign o_beat[k]  = i_beat;
    assign o_valid[k] = i_valid && !cur_drop && (cur_sel == SEL_W'(k));
  end

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      state     <= ST_HEADER;
      body_sel  <= '0;
      body_drop <= 1'b0;
    end else if (fire) begin
      case (state)
        ST_HEADER: begin
          // single-beat packets never leave the header state
          if (!i_beat.last) begin
            state     <= ST_BODY;
            body_sel  <= hdr_sel;
            body_drop <= hdr_drop;
          end
        end
        ST_BODY: begin
          if (i_beat.last)
            state <= ST_HEADER;
        end
        default: state <= ST_HEADER;
      endcase
    end
  end

  // count at the last beat of a dropped packet, saturating
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst)
      drop_count <= '0;
    else if (fire && cur_drop && i_beat.last && (drop_count != '1))
      drop_count <= drop_count + 1'b1;
  end

  assign o_drop_count = drop_count;

endmodule

`default_nettype wire

// ==== rtl/ce_pkt_buffer.sv ====
// store-and-forward packet buffer
// stands in for a computational engine, returns packets unchanged
`timescale 1ns/1ps
`default_nettype none

module ce_pkt_buffer
  import core_pkg::*;
#(
  parameter int DEPTH_LOG2 = 5
) (
  input  wire logic         i_bus_clk,
  input  wire logic         i_bus_rst,
  input  wire stream_beat_t i_beat,
  input  wire logic         i_valid,
  output logic              o_ready,
  output stream_beat_t      o_beat,
  output logic              o_valid,
  input  wire logic         i_ready
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  stream_beat_t          mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   fill;
  logic [DEPTH_LOG2:0]   pkt_count;
  logic                  wr_en;
  logic                  rd_en;
  logic                  wr_last;
  logic                  rd_last;

  assign o_ready = (fill != (DEPTH_LOG2 + 1)'(DEPTH));
  // nothing goes out until a whole packet is in
  assign o_valid = (pkt_count != '0);
  assign o_beat  = mem[rd_ptr];

  assign wr_en   = i_valid && o_ready;
  assign rd_en   = o_valid && i_ready;
  assign wr_last = wr_en && i_beat.last;
  assign rd_last = rd_en && o_beat.last;

  //////////////////////////////////////////////////////////////////////
  // beat storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_bus_clk) begin
    if (wr_en)
      mem[wr_ptr] <= i_beat;
  end

  // pointers wrap naturally at the power-of-two depth
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      fill <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // complete packets held, in and out on the same edge cancel
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      pkt_count <= '0;
    end else begin
      case ({wr_last, rd_last})
        2'b10:   pkt_count <= pkt_count + 1'b1;
        2'b01:   pkt_count <= pkt_count - 1'b1;
        default: pkt_count <= pkt_count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pkt_merge.sv ====
// round-robin packet merge
// one input owns the output from header to last beat
`timescale 1ns/1ps
`default_nettype none

module pkt_merge
  import core_pkg::*;
#(
  parameter int NUM_IN = 2
) (
  input  wire logic              i_bus_clk,
  input  wire logic              i_bus_rst,
  input  wire stream_beat_t      i_beat [NUM_IN],
  input  wire logic [NUM_IN-1:0] i_valid,
  output logic      [NUM_IN-1:0] o_ready,
  output stream_beat_t           o_beat,
  output logic                   o_valid,
  input  wire logic              i_ready
);

  localparam int SEL_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

  route_state_e     state;
  logic [SEL_W-1:0] rr_ptr;
  logic [SEL_W-1:0] grant;
  logic [SEL_W-1:0] pick;
  logic [SEL_W-1:0] cur;
  logic [SEL_W-1:0] next_rr;
  logic             any_valid;
  logic             fire;

  // first valid input at or after the round-robin pointer
  always_comb begin
    int idx;
    pick      = rr_ptr;
    any_valid = 1'b0;
    for (int i = 0; i < NUM_IN; i++) begin
      idx = (int'(rr_ptr) + i) % NUM_IN;
      if (!any_valid && i_valid[idx]) begin
        pick      = SEL_W'(idx);
        any_valid = 1'b1;
      end
    end
  end

  assign cur     = (state == ST_HEADER) ? pick : grant;
  assign o_beat  = i_beat[cur];
  assign o_valid = (state == ST_HEADER) ? any_valid : i_valid[cur];
  assign fire    = o_valid && i_ready;
  assign next_rr = SEL_W'((int'(cur) + 1) % NUM_IN);

  for (genvar k = 0; k < NUM_IN; k++) begin : g_rdy
    assign o_ready[k] = i_ready && (cur == SEL_W'(k));
  end

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      state  <= ST_HEADER;
      grant  <= '0;
      rr_ptr <= '0;
    end else begin
      case (state)
        ST_HEADER: begin
          // lock as soon as a header is shown, so a stalled beat stays put
          if (fire && o_beat.last) begin
            rr_ptr <= next_rr;
          end else if (any_valid) begin
            state <= ST_BODY;
            grant <= pick;
          end
        end
        ST_BODY: begin
          if (fire && o_beat.last) begin
            state  <= ST_HEADER;
            rr_ptr <= next_rr;
          end
        end
        default: state <= ST_HEADER;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/e300_lite_core.sv ====
// reduced two-channel radio routing core
// settings registers, header router, engine slots and host merge
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module e300_lite_core
  import core_pkg::*;
(
  input  wire logic        i_bus_clk,
  input  wire logic        i_bus_rst,
  // host to core stream
  input  wire logic [63:0] i_h2s_tdata,
  input  wire logic        i_h2s_tlast,
  input  wire logic        i_h2s_tvalid,
  output logic             o_h2s_tready,
  // core to host stream
  output logic      [63:0] o_s2h_tdata,
  output logic             o_s2h_tlast,
  output logic             o_s2h_tvalid,
  input  wire logic        i_s2h_tready,
  // settings bus
  input  wire logic        i_set_stb,
  input  wire logic [31:0] i_set_addr,
  input  wire logic [31:0] i_set_data,
  output logic      [31:0] o_rb_data,
  // status inputs
  input  wire logic [1:0]  i_lock_signals,
  input  wire logic [3:0]  i_tcxo_status,
  // misc control outputs
  output logic      [1:0]  o_pps_select,
  output logic             o_mimo,
  output logic             o_codec_arst,
  output logic      [2:0]  o_tx_bandsel,
  output logic      [5:0]  o_rx_bandsel_a,
  output logic      [3:0]  o_rx_bandsel_b,
  output logic      [3:0]  o_rx_bandsel_c
);

  stream_beat_t            h2s_beat;
  stream_beat_t            s2h_beat;
  stream_beat_t            rt_beat [`CORE_NUM_CE];
  logic [`CORE_NUM_CE-1:0] rt_valid;
  logic [`CORE_NUM_CE-1:0] rt_ready;
  stream_beat_t            ce_beat [`CORE_NUM_CE];
  logic [`CORE_NUM_CE-1:0] ce_valid;
  logic [`CORE_NUM_CE-1:0] ce_ready;
  misc_ctrl_t              misc;
  logic [7:0]              xb_local_addr;
  logic [`CORE_DROP_W-1:0] drop_count;

  assign h2s_beat = '{last: i_h2s_tlast, data: i_h2s_tdata};

  core_settings u_settings (
    .i_bus_clk       (i_bus_clk),
    .i_bus_rst       (i_bus_rst),
    .i_set_stb       (i_set_stb),
    .i_set_addr      (i_set_addr),
    .i_set_data      (i_set_data),
    .i_lock_signals  (i_lock_signals),
    .i_tcxo_status   (i_tcxo_status),
    .i_drop_count    (drop_count),
    .o_rb_data       (o_rb_data),
    .o_misc          (misc),
    .o_xb_local_addr (xb_local_addr)
  );

  //////////////////////////////////////////////////////////////////////
  // packet path: router, engines, merge
  //////////////////////////////////////////////////////////////////////

  pkt_router #(.NUM_OUT(`CORE_NUM_CE)) u_router (
    .i_bus_clk    (i_bus_clk),
    .i_bus_rst    (i_bus_rst),
    .i_local_addr (xb_local_addr),
    .i_beat       (h2s_beat),
    .i_valid      (i_h2s_tvalid),
    .o_ready      (o_h2s_tready),
    .o_beat       (rt_beat),
    .o_valid      (rt_valid),
    .i_ready      (rt_ready),
    .o_drop_count (drop_count)
  );

  for (genvar i = 0; i < `CORE_NUM_CE; i++) begin : g_ce
    ce_pkt_buffer #(.DEPTH_LOG2(5)) u_ce (
      .i_bus_clk (i_bus_clk),
      .i_bus_rst (i_bus_rst),
      .i_beat    (rt_beat[i]),
      .i_valid   (rt_valid[i]),
      .o_ready   (rt_ready[i]),
      .o_beat    (ce_beat[i]),
      .o_valid   (ce_valid[i]),
      .i_ready   (ce_ready[i])
    );
  end

  pkt_merge #(.NUM_IN(`CORE_NUM_CE)) u_merge (
    .i_bus_clk (i_bus_clk),
    .i_bus_rst (i_bus_rst),
    .i_beat    (ce_beat),
    .i_valid   (ce_valid),
    .o_ready   (ce_ready),
    .o_beat    (s2h_beat),
    .o_valid   (o_s2h_tvalid),
    .i_ready   (i_s2h_tready)
  );

  assign o_s2h_tdata = s2h_beat.data;
  assign o_s2h_tlast = s2h_beat.last;

  // misc word fields out to the board
  assign o_pps_select   = misc.pps_select;
  assign o_mimo         = misc.mimo;
  assign o_codec_arst   = misc.codec_arst;
  assign o_tx_bandsel   = misc.tx_bandsel;
  assign o_rx_bandsel_a = misc.rx_bandsel_a;
  assign o_rx_bandsel_b = misc.rx_bandsel_b;
  assign o_rx_bandsel_c = misc.rx_bandsel_c;

endmodule

`default_nettype wire

// ==== verif/tb_core.sv ====
// testbench for the reduced routing core
// per-engine packet scoreboard, settings readback and lock sync checks
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module tb_core;

  localparam int GOOD_PKTS = 24;
  localparam int BP_PKTS   = 24;
  localparam int BAD_PKTS  = 8;
  localparam int NEW_PKTS  = 8;
  localparam int NUM_PKTS  = GOOD_PKTS + BP_PKTS + BAD_PKTS + NEW_PKTS + 1;
  localparam int WATCHDOG_CYCLES = 200 * NUM_PKTS * 16 + 2000;

  logic        bus_clk = 1'b0;
  logic        bus_rst;
  logic [63:0] h2s_tdata;
  logic        h2s_tlast;
  logic        h2s_tvalid;
  logic        h2s_tready;
  logic [63:0] s2h_tdata;
  logic        s2h_tlast;
  logic        s2h_tvalid;
  logic        s2h_tready = 1'b1;
  logic        set_stb;
  logic [31:0] set_addr;
  logic [31:0] set_data;
  logic [31:0] rb_data;
  logic [1:0]  lock_signals;
  logic [3:0]  tcxo_status;
  logic [1:0]  pps_select;
  logic        mimo;
  logic        codec_arst;
  logic [2:0]  tx_bandsel;
  logic [5:0]  rx_bandsel_a;
  logic [3:0]  rx_bandsel_b;
  logic [3:0]  rx_bandsel_c;

  // one queue of expected {last, data} beats per engine
  logic [64:0] exp_q [`CORE_NUM_CE][$];
  int          errors = 0;
  int          checks = 0;
  int          mon_errors = 0;
  int          mon_checks = 0;
  int          beats_seen = 0;
  int          drops_sent = 0;
  logic [7:0]  local_addr;
  logic        bp_enable = 1'b0;
  logic [15:0] bp_seed;
  logic [15:0] bp_lfsr;
  logic        mon_in_pkt;
  logic        stall_prev;
  int          mon_eng;
  logic [64:0] stall_beat;

  always #5 bus_clk = ~bus_clk;

  e300_lite_core u_dut (
    .i_bus_clk      (bus_clk),
    .i_bus_rst      (bus_rst),
    .i_h2s_tdata    (h2s_tdata),
    .i_h2s_tlast    (h2s_tlast),
    .i_h2s_tvalid   (h2s_tvalid),
    .o_h2s_tready   (h2s_tready),
    .o_s2h_tdata    (s2h_tdata),
    .o_s2h_tlast    (s2h_tlast),
    .o_s2h_tvalid   (s2h_tvalid),
    .i_s2h_tready   (s2h_tready),
    .i_set_stb      (set_stb),
    .i_set_addr     (set_addr),
    .i_set_data     (set_data),
    .o_rb_data      (rb_data),
    .i_lock_signals (lock_signals),
    .i_tcxo_status  (tcxo_status),
    .o_pps_select   (pps_select),
    .o_mimo         (mimo),
    .o_codec_arst   (codec_arst),
    .o_tx_bandsel   (tx_bandsel),
    .o_rx_bandsel_a (rx_bandsel_a),
    .o_rx_bandsel_b (rx_bandsel_b),
    .o_rx_bandsel_c (rx_bandsel_c)
  );

  //////////////////////////////////////////////////////////////////////
  // host back-pressure
  //////////////////////////////////////////////////////////////////////

  // x^16 + x^15 + x^13 + x^4 + 1
  always @(posedge bus_clk) begin
    if (bus_rst)
      bp_lfsr <= bp_seed;
    else
      bp_lfsr <= {bp_lfsr[14:0], bp_lfsr[15] ^ bp_lfsr[14] ^ bp_lfsr[12] ^ bp_lfsr[3]};
  end

  // ready about three cycles in four while enabled
  always @(negedge bus_clk) begin
    s2h_tready = !bp_enable || (bp_lfsr[1:0] != 2'b00);
  end

  //////////////////////////////////////////////////////////////////////
  // s2h monitor and scoreboard
  //////////////////////////////////////////////////////////////////////

  always @(posedge bus_clk) begin : s2h_monitor
    logic [64:0] got;
    logic [64:0] exp;
    got = {s2h_tlast, s2h_tdata};
    if (bus_rst) begin
      mon_in_pkt = 1'b0;
      stall_prev = 1'b0;
    end else begin
      // a beat offered under back-pressure has to stay put
      if (stall_prev) begin
        mon_checks++;
        assert (s2h_tvalid && got === stall_beat) else begin
          mon_errors++;
          $display("** Error: o_s2h {tlast,tdata} = %h, expected held %h", got, stall_beat);
        end
      end
      stall_prev = s2h_tvalid && !s2h_tready;
      stall_beat = got;
      if (s2h_tvalid && s2h_tready) begin
        beats_seen++;
        mon_checks++;
        // engine index comes from the header of the current packet
        if (!mon_in_pkt)
          mon_eng = int'(s2h_tdata[7:0]);
        mon_in_pkt = !s2h_tlast;
        assert (mon_eng < `CORE_NUM_CE) else begin
          mon_errors++;
          $display("s2h packet names engine %0d, which has no slot", mon_eng);
        end
        if (mon_eng < `CORE_NUM_CE) begin
          assert (exp_q[mon_eng].size() != 0) else begin
            mon_errors++;
            $display("s2h beat for engine %0d arrived with nothing expected", mon_eng);
          end
          if (exp_q[mon_eng].size() != 0) begin
            exp = exp_q[mon_eng].pop_front();
            assert (got === exp) else begin
              mon_errors++;
              $display("** Error: o_s2h {tlast,tdata} = %h, expected %h", got, exp);
            end
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic write_reg(input logic [10:0] addr, input logic [31:0] data);
    set_stb  = 1'b1;
    set_addr = {21'd0, addr};
    set_data = data;
    @(negedge bus_clk);
    set_stb  = 1'b0;
  endtask

  task automatic check_readback(input logic [4:0] sel, input logic [31:0] exp);
    write_reg(`CORE_SR_READBACK, {27'd0, sel});
    @(negedge bus_clk);
    check_eq("o_rb_data", rb_data, exp);
  endtask

  // misc fields from bit 0 up are pps 2, mimo, codec reset, tx 3, rx a 6, b 4, c 4
  task automatic check_misc(input logic [31:0] v);
    check_eq("o_pps_select", 32'(pps_select), 32'(v[1:0]));
    check_eq("o_mimo", 32'(mimo), 32'(v[2]));
    check_eq("o_codec_arst", 32'(codec_arst), 32'(v[3]));
    check_eq("o_tx_bandsel", 32'(tx_bandsel), 32'(v[6:4]));
    check_eq("o_rx_bandsel_a", 32'(rx_bandsel_a), 32'(v[12:7]));
    check_eq("o_rx_bandsel_b", 32'(rx_bandsel_b), 32'(v[16:13]));
    check_eq("o_rx_bandsel_c", 32'(rx_bandsel_c), 32'(v[20:17]));
  endtask

  task automatic set_backpressure(input logic enable);
    @(posedge bus_clk);
    bp_enable = enable;
    @(negedge bus_clk);
  endtask

  // starts on a falling edge and returns on the one after the transfer
  task automatic send_beat(input logic [63:0] data, input logic last, input bit no_stall);
    h2s_tvalid = 1'b1;
    h2s_tdata  = data;
    h2s_tlast  = last;
    #1;
    // a dropped packet is taken one beat per cycle
    if (no_stall)
      check_eq("o_h2s_tready", 32'(h2s_tready), 32'd1);
    while (!h2s_tready) begin
      @(negedge bus_clk);
      #1;
    end
    @(negedge bus_clk);
  endtask

  task automatic send_packet(input logic [7:0] dev, input int eng, input int len,
                             input bit deliver);
    logic [63:0] word;
    for (int i = 0; i < len; i++) begin
      word = {$urandom, $urandom};
      if (i == 0)
        word[15:0] = {dev, 8'(eng)};
      if (deliver)
        exp_q[eng].push_back({(i == len - 1), word});
      send_beat(word, (i == len - 1), !deliver);
    end
    h2s_tvalid = 1'b0;
    if (!deliver)
      drops_sent++;
  endtask

  task automatic wait_drain();
    int pending;
    pending = 1;
    while (pending != 0) begin
      @(negedge bus_clk);
      pending = 0;
      for (int k = 0; k < `CORE_NUM_CE; k++)
        pending += exp_q[k].size();
    end
    // room for any beat that should never have come out
    repeat (40) @(negedge bus_clk);
  endtask

  task automatic check_lock(input logic [1:0] value);
    int n;
    check_readback(`CORE_RB_PLL, {30'd0, lock_signals});
    lock_signals = value;
    n = 0;
    do begin
      @(negedge bus_clk);
      n++;
    end while (rb_data != {30'd0, value} && n < 3);
    check_eq("o_rb_data", rb_data, {30'd0, value});
    checks++;
    assert (n >= 2) else begin
      errors++;
      $display("lock change reached readback after only %0d clock edge", n);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] v;
    void'($urandom(95));
    bp_seed      = 16'($urandom) | 16'h0001;
    bus_rst      = 1'b1;
    h2s_tdata    = '0;
    h2s_tlast    = 1'b0;
    h2s_tvalid   = 1'b0;
    set_stb      = 1'b0;
    set_addr     = '0;
    set_data     = '0;
    lock_signals = 2'b00;
    tcxo_status  = 4'hA;
    local_addr   = `CORE_XB_LOCAL_RESET;
    repeat (4) @(negedge bus_clk);
    bus_rst = 1'b0;
    @(negedge bus_clk);

    // reset values
    check_eq("o_s2h_tvalid", 32'(s2h_tvalid), 32'd0);
    check_misc(`CORE_MISC_RESET);
    check_readback(`CORE_RB_COMPAT, `CORE_COMPAT_WORD);
    check_readback(`CORE_RB_MISC, {26'd0, tcxo_status, 2'b10});
    check_readback(`CORE_RB_DROPS, 32'd0);
    check_readback(5'd3, `CORE_RB_DEFAULT);

    // register writes
    v = $urandom;
    write_reg(`CORE_SR_TEST, v);
    check_readback(`CORE_RB_TEST, v);
    v = $urandom;
    write_reg(`CORE_SR_MISC, v);
    @(negedge bus_clk);
    check_misc(v);

    // traffic to every engine with and without back-pressure
    for (int i = 0; i < GOOD_PKTS; i++)
      send_packet(local_addr, i % `CORE_NUM_CE, 1 + int'($urandom % 16), 1'b1);
    set_backpressure(1'b1);
    for (int i = 0; i < BP_PKTS; i++)
      send_packet(local_addr, int'($urandom % `CORE_NUM_CE), 1 + int'($urandom % 16), 1'b1);
    wait_drain();

    // foreign device and out-of-range engine
    for (int i = 0; i < BAD_PKTS; i++) begin
      if (i % 2 == 0)
        send_packet(local_addr ^ 8'h81, i % `CORE_NUM_CE, 1 + int'($urandom % 16), 1'b0);
      else
        send_packet(local_addr, `CORE_NUM_CE + int'($urandom % 32),
                    1 + int'($urandom % 16), 1'b0);
    end
    wait_drain();
    check_readback(`CORE_RB_DROPS, 32'(drops_sent));

    // the old local address turns foreign after the rewrite
    local_addr = 8'h5A;
    write_reg(`CORE_SR_XB_LOCAL, {24'd0, local_addr});
    @(negedge bus_clk);
    for (int i = 0; i < NEW_PKTS; i++)
      send_packet(local_addr, i % `CORE_NUM_CE, 1 + int'($urandom % 16), 1'b1);
    send_packet(`CORE_XB_LOCAL_RESET, 0, 1 + int'($urandom % 16), 1'b0);
    wait_drain();
    set_backpressure(1'b0);
    check_readback(`CORE_RB_DROPS, 32'(drops_sent));

    // lock synchronizer delay
    check_lock(2'b01);
    check_lock(2'b10);

    $display("checks %0d, errors %0d, s2h beats %0d, packets dropped %0d",
             checks + mon_checks, errors + mon_errors, beats_seen, drops_sent);
    if (errors + mon_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge bus_clk);
    $display("watchdog expired after %0d cycles, the run stalled", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/core_settings.sv
rtl/pkt_router.sv
rtl/ce_pkt_buffer.sv
rtl/pkt_merge.sv
rtl/e300_lite_core.sv
verif/tb_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the routing core testbench with Verilator, run it, grade the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_core -f compile.f -o sim_core \
  && ./obj_dir/sim_core > sim.log 2>&1 \
  || echo "build or simulation stopped with an error" >> sim.log

cat sim.log
grep -qx "TEST OK" sim.log && echo "simulation passed" && exit 0 \
  || echo "simulation failed" && exit 1
